//--- Makefile
# Verilator build and run of the AFU CSR testbench

TOP := tb_afu_csr
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	rm -f $(LOG)
	verilator --binary --timing --top-module $(TOP) -f list.f -Mdir obj_dir -o sim_$(TOP)
	-./obj_dir/sim_$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- design/afu_csr_top.sv
// AFU CSR top level joining the MMIO manager, response statistics and test CSR bank
`timescale 1ns/1ps
`include "afu_csr_cfg.svh"

module afu_csr_top
(
    input  logic                          clk,
    input  logic                          reset,
    // MMIO requests
    input  logic                          mmio_req_valid,
    input  logic                          mmio_req_is_write,
    input  ccip_rsp_pkg::t_mmio_addr      mmio_req_addr,
    input  ccip_rsp_pkg::t_mmio_tid       mmio_req_tid,
    input  ccip_rsp_pkg::t_mmio_data      mmio_req_data,
    // AFU read responses to merge
    input  logic                          afu_rd_valid,
    input  ccip_rsp_pkg::t_mmio_tid       afu_rd_tid,
    input  ccip_rsp_pkg::t_mmio_data      afu_rd_data,
    // Host read and write response headers
    input  logic                          rd_rsp_valid,
    input  logic                          rd_rsp_hit,
    input  ccip_rsp_pkg::t_vc_sel         rd_rsp_vc,
    input  logic                          wr_rsp_valid,
    input  logic                          wr_rsp_hit,
    input  ccip_rsp_pkg::t_vc_sel         wr_rsp_vc,
    input  logic                          wr_rsp_multi,
    input  ccip_rsp_pkg::t_cl_num         wr_rsp_cl_num,
    input  logic                          c0_alm_full,
    input  logic                          c1_alm_full,
    // MMIO read responses
    output logic                          mmio_rsp_valid,
    output ccip_rsp_pkg::t_mmio_tid       mmio_rsp_tid,
    output ccip_rsp_pkg::t_mmio_data      mmio_rsp_data,
    // Test CSRs for the test logic
    output logic [`NUM_TEST_CSRS*64-1:0]  test_csrs
);

    csr_map_pkg::t_test_counter   ctr_rd_hits;
    csr_map_pkg::t_test_counter   ctr_wr_hits;
    csr_map_pkg::t_test_counter   ctr_vl0_rd;
    csr_map_pkg::t_test_counter   ctr_vl0_wr;
    csr_map_pkg::t_test_counter   ctr_vh0;
    csr_map_pkg::t_test_counter   ctr_vh1;

    csr_map_pkg::t_csr_index      csr_rd_sel;
    ccip_rsp_pkg::t_mmio_data     csr_rd_data;
    logic [`NUM_TEST_CSRS-1:0]    csr_wr_en;
    ccip_rsp_pkg::t_mmio_data     csr_wr_data;

    mmio_csr_manager u_manager
    (
        .clk               (clk),
        .reset             (reset),
        .mmio_req_valid    (mmio_req_valid),
        .mmio_req_is_write (mmio_req_is_write),
        .mmio_req_addr     (mmio_req_addr),
        .mmio_req_tid      (mmio_req_tid),
        .mmio_req_data     (mmio_req_data),
        .afu_rd_valid      (afu_rd_valid),
        .afu_rd_tid        (afu_rd_tid),
        .afu_rd_data       (afu_rd_data),
        .c0_alm_full       (c0_alm_full),
        .c1_alm_full       (c1_alm_full),
        .ctr_rd_hits       (ctr_rd_hits),
        .ctr_wr_hits       (ctr_wr_hits),
        .ctr_vl0_rd        (ctr_vl0_rd),
        .ctr_vl0_wr        (ctr_vl0_wr),
        .ctr_vh0           (ctr_vh0),
        .ctr_vh1           (ctr_vh1),
        .csr_rd_data       (csr_rd_data),
        .csr_rd_sel        (csr_rd_sel),
        .csr_wr_en         (csr_wr_en),
        .csr_wr_data       (csr_wr_data),
        .mmio_rsp_valid    (mmio_rsp_valid),
        .mmio_rsp_tid      (mmio_rsp_tid),
        .mmio_rsp_data     (mmio_rsp_data)
    );

    rsp_channel_stats u_stats
    (
        .clk           (clk),
        .reset         (reset),
        .rd_rsp_valid  (rd_rsp_valid),
        .rd_rsp_hit    (rd_rsp_hit),
        .rd_rsp_vc     (rd_rsp_vc),
        .wr_rsp_valid  (wr_rsp_valid),
        .wr_rsp_hit    (wr_rsp_hit),
        .wr_rsp_vc     (wr_rsp_vc),
        .wr_rsp_multi  (wr_rsp_multi),
        .wr_rsp_cl_num (wr_rsp_cl_num),
        .ctr_rd_hits   (ctr_rd_hits),
        .ctr_wr_hits   (ctr_wr_hits),
        .ctr_vl0_rd    (ctr_vl0_rd),
        .ctr_vl0_wr    (ctr_vl0_wr),
        .ctr_vh0       (ctr_vh0),
        .ctr_vh1       (ctr_vh1)
    );

    test_csr_bank u_bank
    (
        .clk         (clk),
        .reset       (reset),
        .csr_wr_en   (csr_wr_en),
        .csr_wr_data (csr_wr_data),
        .csr_rd_sel  (csr_rd_sel),
        .csr_rd_data (csr_rd_data),
        .test_csrs   (test_csrs)
    );

endmodule

//--- design/ccip_rsp_pkg.sv
// Host channel types: virtual channels, MMIO fields and multi-line counts
package ccip_rsp_pkg;

    // Virtual channel that carried a response
    typedef enum logic [1:0]
    {
        vc_va  = 2'd0,
        vc_vl0 = 2'd1,
        vc_vh0 = 2'd2,
        vc_vh1 = 2'd3
    } t_vc_sel;

    // MMIO transaction ID, echoed back on the read response
    typedef logic [8:0] t_mmio_tid;

    // MMIO address in 32-bit word units
    typedef logic [15:0] t_mmio_addr;

    // MMIO payload, one 64-bit CSR
    typedef logic [63:0] t_mmio_data;

    // Extra lines in a multi-line response, total is cl_num + 1
    typedef logic [1:0] t_cl_num;

endpackage

//--- design/csr_map_pkg.sv
// CSR space types: local index, counter, feature type and DFH layout
`include "afu_csr_cfg.svh"

package csr_map_pkg;

    // Local CSR index, one step per 64-bit CSR
    typedef logic [5:0] t_csr_index;

    // Response statistics counter
    typedef logic [`TEST_COUNTER_BITS-1:0] t_test_counter;

    // DFH feature type codes
    typedef enum logic [3:0]
    {
        ftype_afu = 4'd1
    } t_feature_type;

    // Device feature header, MSB first
    typedef struct packed
    {
        t_feature_type feature_type;
        logic [18:0]   reserved;
        logic          end_of_list;
        logic [23:0]   next_feature;
        logic [15:0]   feature_id;
    } t_dfh;

endpackage

//--- design/mmio_csr_manager.sv
// MMIO CSR manager decoding the local window, answering reads and merging AFU reads
`timescale 1ns/1ps
`include "afu_csr_cfg.svh"

module mmio_csr_manager
(
    input  logic                          clk,
    input  logic                          reset,
    // MMIO request stream from the host
    input  logic                          mmio_req_valid,
    input  logic                          mmio_req_is_write,
    input  ccip_rsp_pkg::t_mmio_addr      mmio_req_addr,
    input  ccip_rsp_pkg::t_mmio_tid       mmio_req_tid,
    input  ccip_rsp_pkg::t_mmio_data      mmio_req_data,
    // Read responses from the rest of the AFU
    input  logic                          afu_rd_valid,
    input  ccip_rsp_pkg::t_mmio_tid       afu_rd_tid,
    input  ccip_rsp_pkg::t_mmio_data      afu_rd_data,
    input  logic                          c0_alm_full,
    input  logic                          c1_alm_full,
    // Statistics counters
    input  csr_map_pkg::t_test_counter    ctr_rd_hits,
    input  csr_map_pkg::t_test_counter    ctr_wr_hits,
    input  csr_map_pkg::t_test_counter    ctr_vl0_rd,
    input  csr_map_pkg::t_test_counter    ctr_vl0_wr,
    input  csr_map_pkg::t_test_counter    ctr_vh0,
    input  csr_map_pkg::t_test_counter    ctr_vh1,
    // Test CSR bank
    input  ccip_rsp_pkg::t_mmio_data      csr_rd_data,
    output csr_map_pkg::t_csr_index       csr_rd_sel,
    output logic [`NUM_TEST_CSRS-1:0]     csr_wr_en,
    output ccip_rsp_pkg::t_mmio_data      csr_wr_data,
    // Merged MMIO read response toward the host
    output logic                          mmio_rsp_valid,
    output ccip_rsp_pkg::t_mmio_tid       mmio_rsp_tid,
    output ccip_rsp_pkg::t_mmio_data      mmio_rsp_data
);

    // Window covers every 64-bit CSR up to the end of the test bank
    localparam int WINDOW_WORDS = 2 * (`TEST_CSR_BASE + `NUM_TEST_CSRS);
    localparam logic [127:0] AFU_ID = `AFU_ID_VALUE;

    logic                       req_valid_q;
    logic                       req_is_write_q;
    ccip_rsp_pkg::t_mmio_addr   req_addr_q;
    ccip_rsp_pkg::t_mmio_tid    req_tid_q;
    ccip_rsp_pkg::t_mmio_data   req_data_q;

    logic                       in_window;
    logic                       local_rd;
    logic                       local_wr;
    csr_map_pkg::t_csr_index    csr_index;
    csr_map_pkg::t_dfh          afu_dfh;
    ccip_rsp_pkg::t_mmio_data   rd_data;

    // Capture the request one cycle after its strobe
    always_ff @(posedge clk)
    begin
        req_valid_q    <= mmio_req_valid;
        req_is_write_q <= mmio_req_is_write;
        req_addr_q     <= mmio_req_addr;
        req_tid_q      <= mmio_req_tid;
        req_data_q     <= mmio_req_data;

        if (reset)
        begin
            req_valid_q <= 1'b0;
        end
    end

    // Requests outside the window belong to the rest of the AFU
    assign in_window = (req_addr_q < ccip_rsp_pkg::t_mmio_addr'(WINDOW_WORDS));
    assign local_rd  = req_valid_q && !req_is_write_q && in_window;
    assign local_wr  = req_valid_q && req_is_write_q && in_window;

    // Two 32-bit words per CSR
    assign csr_index  = csr_map_pkg::t_csr_index'(req_addr_q >> 1);
    assign csr_rd_sel = csr_index;

    // Feature header for CSR 0
    always_comb
    begin
        afu_dfh              = '0;
        afu_dfh.feature_type = csr_map_pkg::ftype_afu;
        afu_dfh.next_feature = `NEXT_DFH_OFFSET;
        // Last feature in the list when nothing follows
        afu_dfh.end_of_list  = (`NEXT_DFH_OFFSET == 24'h0);
    end

    // Read multiplexer
    always_comb
    begin
        rd_data = '0;
        // Test bank from the base up, window limits the top end
        if (csr_index >= csr_map_pkg::t_csr_index'(`TEST_CSR_BASE))
        begin
            rd_data = csr_rd_data;
        end
        else
        begin
            case (csr_index)
                6'd0:  rd_data = afu_dfh;
                6'd1:  rd_data = AFU_ID[63:0];
                6'd2:  rd_data = AFU_ID[127:64];
                // CSRs 3 and 4 are reserved and read as zero by default
                6'd8:  rd_data = 64'(`AFU_CLOCK_FREQ);
                6'd9:  rd_data = 64'(ctr_rd_hits);
                6'd10: rd_data = 64'(ctr_wr_hits);
                6'd11: rd_data = 64'(ctr_vl0_rd);
                6'd12: rd_data = 64'(ctr_vl0_wr);
                6'd13: rd_data = 64'(ctr_vh0);
                6'd14: rd_data = 64'(ctr_vh1);
                6'd15: rd_data = {62'b0, c1_alm_full, c0_alm_full};
                default: rd_data = '0;
            endcase
        end
    end

    // Response register, local reads take priority and a colliding AFU read is lost
    always_ff @(posedge clk)
    begin
        mmio_rsp_valid <= local_rd || afu_rd_valid;

        if (local_rd)
        begin
            mmio_rsp_tid  <= req_tid_q;
            mmio_rsp_data <= rd_data;
        end
        else
        begin
            mmio_rsp_tid  <= afu_rd_tid;
            mmio_rsp_data <= afu_rd_data;
        end

        if (reset)
        begin
            mmio_rsp_valid <= 1'b0;
        end
    end

    // Write fan-out, data goes to every CSR and only the addressed one is enabled
    always_ff @(posedge clk)
    begin
        csr_wr_data <= req_data_q;

        for (int i = 0; i < `NUM_TEST_CSRS; i++)
        begin
            csr_wr_en[i] <= local_wr &&
                (csr_index == csr_map_pkg::t_csr_index'(`TEST_CSR_BASE + i));
        end

        if (reset)
        begin
            csr_wr_en <= '0;
        end
    end

endmodule

//--- design/rsp_channel_stats.sv
// Response statistics: cache hits and per virtual channel line counts
`timescale 1ns/1ps

module rsp_channel_stats
(
    input  logic                          clk,
    input  logic                          reset,
    // Read response header fields
    input  logic                          rd_rsp_valid,
    input  logic                          rd_rsp_hit,
    input  ccip_rsp_pkg::t_vc_sel         rd_rsp_vc,
    // Write response header fields
    input  logic                          wr_rsp_valid,
    input  logic                          wr_rsp_hit,
    input  ccip_rsp_pkg::t_vc_sel         wr_rsp_vc,
    input  logic                          wr_rsp_multi,
    input  ccip_rsp_pkg::t_cl_num         wr_rsp_cl_num,
    // Counters
    output csr_map_pkg::t_test_counter    ctr_rd_hits,
    output csr_map_pkg::t_test_counter    ctr_wr_hits,
    output csr_map_pkg::t_test_counter    ctr_vl0_rd,
    output csr_map_pkg::t_test_counter    ctr_vl0_wr,
    output csr_map_pkg::t_test_counter    ctr_vh0,
    output csr_map_pkg::t_test_counter    ctr_vh1
);

    // Captured response headers
    logic                       rd_valid_q;
    logic                       rd_hit_q;
    ccip_rsp_pkg::t_vc_sel      rd_vc_q;
    logic                       wr_valid_q;
    logic                       wr_hit_q;
    ccip_rsp_pkg::t_vc_sel      wr_vc_q;
    logic                       wr_multi_q;
    ccip_rsp_pkg::t_cl_num      wr_cl_num_q;

    // Lines carried by the captured write response
    logic [2:0]                 wr_len;
    logic [2:0]                 wr_len_vl0;
    logic [2:0]                 wr_len_vh0;
    logic [2:0]                 wr_len_vh1;

    // Staged increments, at most one read plus four write lines per cycle
    logic                       rd_hit_inc;
    logic [2:0]                 wr_hit_inc;
    logic                       vl0_rd_inc;
    logic [2:0]                 vl0_wr_inc;
    logic [2:0]                 vh0_inc;
    logic [2:0]                 vh1_inc;

    always_ff @(posedge clk)
    begin
        rd_valid_q  <= rd_rsp_valid;
        rd_hit_q    <= rd_rsp_hit;
        rd_vc_q     <= rd_rsp_vc;
        wr_valid_q  <= wr_rsp_valid;
        wr_hit_q    <= wr_rsp_hit;
        wr_vc_q     <= wr_rsp_vc;
        wr_multi_q  <= wr_rsp_multi;
        wr_cl_num_q <= wr_rsp_cl_num;

        if (reset)
        begin
            rd_valid_q <= 1'b0;
            wr_valid_q <= 1'b0;
        end
    end

    // Single line unless the multi-line format is set
    assign wr_len = 3'd1 + (wr_multi_q ? 3'(wr_cl_num_q) : 3'd0);

    assign wr_len_vl0 = (wr_valid_q && wr_vc_q == ccip_rsp_pkg::vc_vl0) ? wr_len : 3'd0;
    assign wr_len_vh0 = (wr_valid_q && wr_vc_q == ccip_rsp_pkg::vc_vh0) ? wr_len : 3'd0;
    assign wr_len_vh1 = (wr_valid_q && wr_vc_q == ccip_rsp_pkg::vc_vh1) ? wr_len : 3'd0;

    // Stage the increments so the counter adders see registered inputs
    always_ff @(posedge clk)
    begin
        rd_hit_inc <= rd_valid_q && rd_hit_q;
        wr_hit_inc <= (wr_valid_q && wr_hit_q) ? wr_len : 3'd0;
        vl0_rd_inc <= rd_valid_q && (rd_vc_q == ccip_rsp_pkg::vc_vl0);
        vl0_wr_inc <= wr_len_vl0;
        // VH channels mix reads and write lines in one count
        vh0_inc    <= 3'(rd_valid_q && (rd_vc_q == ccip_rsp_pkg::vc_vh0)) + wr_len_vh0;
        vh1_inc    <= 3'(rd_valid_q && (rd_vc_q == ccip_rsp_pkg::vc_vh1)) + wr_len_vh1;

        if (reset)
        begin
            rd_hit_inc <= 1'b0;
            wr_hit_inc <= 3'd0;
            vl0_rd_inc <= 1'b0;
            vl0_wr_inc <= 3'd0;
            vh0_inc    <= 3'd0;
            vh1_inc    <= 3'd0;
        end
    end

    // Counters, VA traffic only shows up in the hit counts
    always_ff @(posedge clk)
    begin
        ctr_rd_hits <= ctr_rd_hits + csr_map_pkg::t_test_counter'(rd_hit_inc);
        ctr_wr_hits <= ctr_wr_hits + csr_map_pkg::t_test_counter'(wr_hit_inc);
        ctr_vl0_rd  <= ctr_vl0_rd + csr_map_pkg::t_test_counter'(vl0_rd_inc);
        ctr_vl0_wr  <= ctr_vl0_wr + csr_map_pkg::t_test_counter'(vl0_wr_inc);
        ctr_vh0     <= ctr_vh0 + csr_map_pkg::t_test_counter'(vh0_inc);
        ctr_vh1     <= ctr_vh1 + csr_map_pkg::t_test_counter'(vh1_inc);

        if (reset)
        begin
            ctr_rd_hits <= '0;
            ctr_wr_hits <= '0;
            ctr_vl0_rd  <= '0;
            ctr_vl0_wr  <= '0;
            ctr_vh0     <= '0;
            ctr_vh1     <= '0;
        end
    end

endmodule

//--- design/test_csr_bank.sv
// Test CSR bank written by the host, read back by index and exported to test logic
`timescale 1ns/1ps
`include "afu_csr_cfg.svh"

module test_csr_bank
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic [`NUM_TEST_CSRS-1:0]          csr_wr_en,
    input  ccip_rsp_pkg::t_mmio_data           csr_wr_data,
    input  csr_map_pkg::t_csr_index            csr_rd_sel,
    output ccip_rsp_pkg::t_mmio_data           csr_rd_data,
    // Flattened bank, CSR i in bits [64*i +: 64]
    output logic [`NUM_TEST_CSRS*64-1:0]       test_csrs
);

    localparam int SEL_BITS = (`NUM_TEST_CSRS > 1) ? $clog2(`NUM_TEST_CSRS) : 1;

    ccip_rsp_pkg::t_mmio_data   regs [`NUM_TEST_CSRS];
    csr_map_pkg::t_csr_index    rd_off;
    logic [SEL_BITS-1:0]        rd_idx;

    // Each register loads on its own enable
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < `NUM_TEST_CSRS; i++)
        begin
            if (csr_wr_en[i])
            begin
                regs[i] <= csr_wr_data;
            end
        end

        if (reset)
        begin
            for (int i = 0; i < `NUM_TEST_CSRS; i++)
            begin
                regs[i] <= '0;
            end
        end
    end

    // Bank index relative to the first test CSR
    assign rd_off = csr_rd_sel - csr_map_pkg::t_csr_index'(`TEST_CSR_BASE);
    assign rd_idx = rd_off[SEL_BITS-1:0];

    always_comb
    begin
        csr_rd_data = regs[rd_idx];
        // Forward a write in flight so a read right behind it sees the new value
        if (csr_wr_en[rd_idx])
        begin
            csr_rd_data = csr_wr_data;
        end
    end

    always_comb
    begin
        for (int i = 0; i < `NUM_TEST_CSRS; i++)
        begin
            test_csrs[i*64 +: 64] = regs[i];
        end
    end

endmodule

//--- include/afu_csr_cfg.svh
// AFU CSR configuration: bank size, identity values and counter width
`ifndef AFU_CSR_CFG_SVH
`define AFU_CSR_CFG_SVH

// Number of host-writable test CSRs
`define NUM_TEST_CSRS 8

// First local CSR index of the test CSR bank
`define TEST_CSR_BASE 32

// AFU clock frequency in MHz, reported at CSR 8
`define AFU_CLOCK_FREQ 400

// 128-bit AFU identifier, low half at CSR 1 and high half at CSR 2
`define AFU_ID_VALUE 128'h5f3c9a21_07be_4d6e_b1c8_2a94e0d7361f

// Width of the response statistics counters
`define TEST_COUNTER_BITS 48

// Byte offset of the next feature header, zero when this is the last one
`define NEXT_DFH_OFFSET 24'h0

`endif

//--- list.f
+incdir+include
design/ccip_rsp_pkg.sv
design/csr_map_pkg.sv
design/mmio_csr_manager.sv
design/rsp_channel_stats.sv
design/test_csr_bank.sv
design/afu_csr_top.sv
tests/tb_clock_gen.sv
tests/tb_afu_csr.sv

//--- tests/tb_afu_csr.sv
// AFU CSR testbench with reference model, response scoreboard and timeout
`timescale 1ns/1ps
`include "afu_csr_cfg.svh"

module tb_afu_csr;

    localparam logic [31:0] SEED = 32'h6e336be8;
    localparam int WINDOW_WORDS = 2 * (`TEST_CSR_BASE + `NUM_TEST_CSRS);
    // Operation counts per test, they size the timeout
    localparam int N_ID_READS = 6;
    localparam int N_ALM_READS = 4;
    localparam int N_CSR_WRITES = 16;
    localparam int N_RSP_CYCLES = 40;
    localparam int N_WINDOW_OPS = 14;
    localparam int N_MERGE = 8;
    localparam int N_AFU_BURST = 6;
    localparam int NUM_OPS = N_ID_READS + N_ALM_READS + 2 * N_CSR_WRITES + N_RSP_CYCLES + 6
        + N_WINDOW_OPS + 2 * N_MERGE + N_AFU_BURST;
    localparam int TIMEOUT_CYCLES = 40 * NUM_OPS + 200;

    // One expected read response and the cycle it must show up in
    typedef struct packed
    {
        ccip_rsp_pkg::t_mmio_tid    tid;
        ccip_rsp_pkg::t_mmio_data   data;
        int                         due;
    } t_exp_rsp;

    logic                           clk;
    logic                           reset;
    logic                           mmio_req_valid;
    logic                           mmio_req_is_write;
    ccip_rsp_pkg::t_mmio_addr       mmio_req_addr;
    ccip_rsp_pkg::t_mmio_tid        mmio_req_tid;
    ccip_rsp_pkg::t_mmio_data       mmio_req_data;
    logic                           afu_rd_valid;
    ccip_rsp_pkg::t_mmio_tid        afu_rd_tid;
    ccip_rsp_pkg::t_mmio_data       afu_rd_data;
    logic                           rd_rsp_valid;
    logic                           rd_rsp_hit;
    ccip_rsp_pkg::t_vc_sel          rd_rsp_vc;
    logic                           wr_rsp_valid;
    logic                           wr_rsp_hit;
    ccip_rsp_pkg::t_vc_sel          wr_rsp_vc;
    logic                           wr_rsp_multi;
    ccip_rsp_pkg::t_cl_num          wr_rsp_cl_num;
    logic                           c0_alm_full;
    logic                           c1_alm_full;
    logic                           mmio_rsp_valid;
    ccip_rsp_pkg::t_mmio_tid        mmio_rsp_tid;
    ccip_rsp_pkg::t_mmio_data       mmio_rsp_data;
    logic [`NUM_TEST_CSRS*64-1:0]   test_csrs;

    // Reference model state
    ccip_rsp_pkg::t_mmio_data       bank_model [`NUM_TEST_CSRS];
    csr_map_pkg::t_test_counter     ctr_model [6];
    logic [1:0]                     alm_model;
    t_exp_rsp                       exp_q [$];
    logic [31:0]                    rng_state = SEED;
    int                             cycle = 0;

    int id_csrs [N_ID_READS] = '{0, 1, 2, 3, 4, 8};
    int unmapped_csrs [6] = '{5, 6, 7, 16, 20, 31};
    // Upper two alias onto index 32 once truncated to six bits
    ccip_rsp_pkg::t_mmio_addr outside_addrs [4] = '{16'd80, 16'd81, 16'd192, 16'h8040};

    tb_clock_gen #(.PERIOD_NS(8.0)) u_clock_gen (.clk(clk));

    afu_csr_top u_afu_csr_top
    (
        .clk (clk), .reset (reset),
        .mmio_req_valid (mmio_req_valid), .mmio_req_is_write (mmio_req_is_write),
        .mmio_req_addr (mmio_req_addr), .mmio_req_tid (mmio_req_tid),
        .mmio_req_data (mmio_req_data),
        .afu_rd_valid (afu_rd_valid), .afu_rd_tid (afu_rd_tid), .afu_rd_data (afu_rd_data),
        .rd_rsp_valid (rd_rsp_valid), .rd_rsp_hit (rd_rsp_hit), .rd_rsp_vc (rd_rsp_vc),
        .wr_rsp_valid (wr_rsp_valid), .wr_rsp_hit (wr_rsp_hit), .wr_rsp_vc (wr_rsp_vc),
        .wr_rsp_multi (wr_rsp_multi), .wr_rsp_cl_num (wr_rsp_cl_num),
        .c0_alm_full (c0_alm_full), .c1_alm_full (c1_alm_full),
        .mmio_rsp_valid (mmio_rsp_valid), .mmio_rsp_tid (mmio_rsp_tid),
        .mmio_rsp_data (mmio_rsp_data), .test_csrs (test_csrs)
    );

    // Xorshift32 generator
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Word address of a CSR, either word of the pair
    function automatic ccip_rsp_pkg::t_mmio_addr csr_addr(input int idx);
        return ccip_rsp_pkg::t_mmio_addr'(2 * idx + int'(next_rand() & 32'd1));
    endfunction

    // Expected contents of an in-window CSR
    function automatic ccip_rsp_pkg::t_mmio_data expected_csr(input int idx);
        csr_map_pkg::t_dfh          dfh;
        logic [127:0]               afu_id;
        ccip_rsp_pkg::t_mmio_data   value;
        afu_id = `AFU_ID_VALUE;
        dfh = '0;
        dfh.feature_type = csr_map_pkg::ftype_afu;
        dfh.next_feature = `NEXT_DFH_OFFSET;
        // Zero offset marks the last feature in the list
        dfh.end_of_list = (`NEXT_DFH_OFFSET == 24'h0);
        value = '0;
        if (idx >= `TEST_CSR_BASE)
        begin
            value = bank_model[idx - `TEST_CSR_BASE];
        end
        else
        begin
            case (idx)
                0: value = dfh;
                1: value = afu_id[63:0];
                2: value = afu_id[127:64];
                8: value = 64'(`AFU_CLOCK_FREQ);
                9, 10, 11, 12, 13, 14: value = 64'(ctr_model[idx - 9]);
                15: value = {62'b0, alm_model};
                default: value = '0;
            endcase
        end
        return value;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "Run stopped in cycle %0d", cycle);
    endtask

    task automatic check_rsp_data(input ccip_rsp_pkg::t_mmio_data got,
                                  input ccip_rsp_pkg::t_mmio_data exp);
        if (got !== exp)
        begin
            fail_run($sformatf("** Error: mmio_rsp_data = %h, expected %h", got, exp));
        end
    endtask

    task automatic check_rsp_tid(input ccip_rsp_pkg::t_mmio_tid got,
                                 input ccip_rsp_pkg::t_mmio_tid exp);
        if (got !== exp)
        begin
            fail_run($sformatf("** Error: mmio_rsp_tid = %h, expected %h", got, exp));
        end
    endtask

    task automatic check_test_csr(input int idx, input ccip_rsp_pkg::t_mmio_data got,
                                  input ccip_rsp_pkg::t_mmio_data exp);
        if (got !== exp)
        begin
            fail_run($sformatf("** Error: test_csrs[%0d] = %h, expected %h", idx, got, exp));
        end
    endtask

    task automatic check_bank_all();
        for (int i = 0; i < `NUM_TEST_CSRS; i++)
        begin
            check_test_csr(i, test_csrs[i*64 +: 64], bank_model[i]);
        end
    endtask

    // Next edge plus drive delay, all strobes drop back to idle
    task automatic step();
        @(posedge clk);
        #1;
        mmio_req_valid = 1'b0;
        afu_rd_valid   = 1'b0;
        rd_rsp_valid   = 1'b0;
        wr_rsp_valid   = 1'b0;
    endtask

    task automatic issue_read(input ccip_rsp_pkg::t_mmio_addr addr);
        t_exp_rsp exp_rsp;
        mmio_req_valid    = 1'b1;
        mmio_req_is_write = 1'b0;
        mmio_req_addr     = addr;
        mmio_req_tid      = ccip_rsp_pkg::t_mmio_tid'(next_rand());
        // Local reads answer two cycles later, outside reads never
        if (int'(addr) < WINDOW_WORDS)
        begin
            exp_rsp.tid  = mmio_req_tid;
            exp_rsp.data = expected_csr(int'(addr >> 1));
            exp_rsp.due  = cycle + 2;
            exp_q.push_back(exp_rsp);
        end
    endtask

    task automatic issue_write(input ccip_rsp_pkg::t_mmio_addr addr,
                               input ccip_rsp_pkg::t_mmio_data data);
        int idx;
        mmio_req_valid    = 1'b1;
        mmio_req_is_write = 1'b1;
        mmio_req_addr     = addr;
        mmio_req_tid      = '0;
        mmio_req_data     = data;
        idx = int'(addr >> 1);
        if (int'(addr) < WINDOW_WORDS && idx >= `TEST_CSR_BASE)
        begin
            bank_model[idx - `TEST_CSR_BASE] = data;
        end
    endtask

    // AFU read, passes through one cycle later
    task automatic issue_afu();
        t_exp_rsp exp_rsp;
        afu_rd_valid = 1'b1;
        afu_rd_tid   = ccip_rsp_pkg::t_mmio_tid'(next_rand());
        afu_rd_data  = {next_rand(), next_rand()};
        exp_rsp.tid  = afu_rd_tid;
        exp_rsp.data = afu_rd_data;
        exp_rsp.due  = cycle + 1;
        exp_q.push_back(exp_rsp);
    endtask

    // Random response headers, the model counts lines as they are driven
    task automatic drive_responses();
        logic [31:0]                r;
        csr_map_pkg::t_test_counter len;
        r = next_rand();
        rd_rsp_valid  = r[0];
        rd_rsp_hit    = r[1];
        rd_rsp_vc     = ccip_rsp_pkg::t_vc_sel'(r[3:2]);
        wr_rsp_valid  = r[4];
        wr_rsp_hit    = r[5];
        wr_rsp_vc     = ccip_rsp_pkg::t_vc_sel'(r[7:6]);
        wr_rsp_multi  = r[8];
        wr_rsp_cl_num = r[10:9];
        if (rd_rsp_valid)
        begin
            if (rd_rsp_hit)
                ctr_model[0] = ctr_model[0] + csr_map_pkg::t_test_counter'(1);
            case (rd_rsp_vc)
                ccip_rsp_pkg::vc_vl0: ctr_model[2] = ctr_model[2] + csr_map_pkg::t_test_counter'(1);
                ccip_rsp_pkg::vc_vh0: ctr_model[4] = ctr_model[4] + csr_map_pkg::t_test_counter'(1);
                ccip_rsp_pkg::vc_vh1: ctr_model[5] = ctr_model[5] + csr_map_pkg::t_test_counter'(1);
                default: ;
            endcase
        end
        if (wr_rsp_valid)
        begin
            // One line, plus cl_num more in multi-line format
            len = csr_map_pkg::t_test_counter'(1)
                + (wr_rsp_multi ? csr_map_pkg::t_test_counter'(wr_rsp_cl_num) : '0);
            if (wr_rsp_hit)
                ctr_model[1] = ctr_model[1] + len;
            case (wr_rsp_vc)
                ccip_rsp_pkg::vc_vl0: ctr_model[3] = ctr_model[3] + len;
                ccip_rsp_pkg::vc_vh0: ctr_model[4] = ctr_model[4] + len;
                ccip_rsp_pkg::vc_vh1: ctr_model[5] = ctr_model[5] + len;
                default: ;
            endcase
        end
    endtask

    // Cycle count and watchdog
    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES)
            fail_run($sformatf("Timeout after %0d cycles with responses still pending", cycle));
    end

    // Scoreboard, sampled mid-cycle where outputs are settled
    always @(negedge clk)
    begin : compare_rsp
        t_exp_rsp head;
        if (!reset)
        begin
            if (mmio_rsp_valid)
            begin
                if (exp_q.size() == 0)
                    fail_run("Read response arrived while none was expected");
                head = exp_q.pop_front();
                if (head.due != cycle)
                    fail_run($sformatf("Read response came in cycle %0d, expected in cycle %0d",
                        cycle, head.due));
                check_rsp_tid(mmio_rsp_tid, head.tid);
                check_rsp_data(mmio_rsp_data, head.data);
            end
            else if (exp_q.size() != 0 && exp_q[0].due <= cycle)
            begin
                fail_run($sformatf("Read response due in cycle %0d never came", exp_q[0].due));
            end
        end
    end

    initial
    begin
        int csr_idx;
        ccip_rsp_pkg::t_mmio_addr addr;
        reset = 1'b1;
        mmio_req_valid = 1'b0;
        mmio_req_is_write = 1'b0;
        mmio_req_addr = '0;
        mmio_req_tid = '0;
        mmio_req_data = '0;
        afu_rd_valid = 1'b0;
        afu_rd_tid = '0;
        afu_rd_data = '0;
        rd_rsp_valid = 1'b0;
        rd_rsp_hit = 1'b0;
        rd_rsp_vc = ccip_rsp_pkg::vc_va;
        wr_rsp_valid = 1'b0;
        wr_rsp_hit = 1'b0;
        wr_rsp_vc = ccip_rsp_pkg::vc_va;
        wr_rsp_multi = 1'b0;
        wr_rsp_cl_num = '0;
        c0_alm_full = 1'b0;
        c1_alm_full = 1'b0;
        alm_model = 2'b00;
        foreach (bank_model[i])
            bank_model[i] = '0;
        foreach (ctr_model[i])
            ctr_model[i] = '0;

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        // Bank must come out of reset cleared
        check_bank_all();

        // Identity registers, back to back
        foreach (id_csrs[i])
        begin
            issue_read(csr_addr(id_csrs[i]));
            step();
        end

        // Almost-full flags, held until the read has been answered
        for (int k = 0; k < N_ALM_READS; k++)
        begin
            {c1_alm_full, c0_alm_full} = 2'(k);
            alm_model = 2'(k);
            issue_read(csr_addr(15));
            repeat (3) step();
        end

        // Test CSR writes, each read back on the very next cycle
        for (int k = 0; k < N_CSR_WRITES; k++)
        begin
            csr_idx = `TEST_CSR_BASE + int'(next_rand() % `NUM_TEST_CSRS);
            issue_write(csr_addr(csr_idx), {next_rand(), next_rand()});
            step();
            issue_read(csr_addr(csr_idx));
            repeat (3) step();
            check_bank_all();
        end

        // Response statistics, then a settling gap before reading counters
        for (int k = 0; k < N_RSP_CYCLES; k++)
        begin
            drive_responses();
            step();
        end
        repeat (4) step();
        for (int idx = 9; idx <= 14; idx++)
        begin
            issue_read(csr_addr(idx));
            step();
        end

        // Unmapped CSRs inside the window read as zero
        foreach (unmapped_csrs[i])
        begin
            issue_read(csr_addr(unmapped_csrs[i]));
            step();
        end
        // Outside the window nothing answers and nothing is written
        foreach (outside_addrs[i])
        begin
            issue_read(outside_addrs[i]);
            step();
        end
        foreach (outside_addrs[i])
        begin
            addr = outside_addrs[i];
            issue_write(addr, {next_rand(), next_rand()});
            step();
        end
        repeat (3) step();
        check_bank_all();

        // Merge path, AFU and local read together; AFU queued first as it is due first
        for (int k = 0; k < N_MERGE; k++)
        begin
            issue_afu();
            issue_read(csr_addr(`TEST_CSR_BASE + k % `NUM_TEST_CSRS));
            repeat (2) step();
        end
        for (int k = 0; k < N_AFU_BURST; k++)
        begin
            issue_afu();
            step();
        end

        // Drain, long enough for a stray response to be caught
        repeat (8) step();
        if (exp_q.size() == 0)
        begin
            $display("All tests passed");
            $finish;
        end
        else
        begin
            fail_run($sformatf("%0d expected read responses never came", exp_q.size()));
        end
    end

endmodule

//--- tests/tb_clock_gen.sv
// Testbench clock source, free running from time zero
`timescale 1ns/1ps

module tb_clock_gen
#(
    parameter real PERIOD_NS = 8.0
)
(
    output logic clk
);

    // Starts low so the first rising edge lands half a period in
    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule
